/* rc4_decrypt.f */
rc4_pkg.sv
s_box_ram.sv
rc4_keystream.sv
keystream_fifo.sv
rc4_xor_stage.sv
rc4_decrypt_top.sv
rc4_props.sv
rc4_tb.sv

/* rc4_tb.sv */
`default_nettype none

module rc4_tb;
    import rc4_pkg::*;

    localparam int MSG_LEN      = 32;              // Bytes decrypted per run
    localparam int FIFO_DEPTH   = 4;
    localparam int QUIET_CYCLES = 20;              // Idle window after reset and after done
    localparam int CYCLE_LIMIT  = 12000;           // About 1800 cycles per run over six runs

    typedef logic [MAX_MSG_LEN-1:0][7:0] msg_vec_t; // Whole message with byte n at [n]

    logic        clk;
    logic        reset_n;
    logic        start;
    rc4_key_t    secret_key;
    logic        ct_load;
    ct_write_t   ct_in;
    logic        pt_valid;
    pt_beat_t    pt_out;
    logic        done;

    msg_vec_t    ct_bytes;                         // Ciphertext loaded for this run
    msg_vec_t    exp_pt;                           // Expected plaintext
    int          exp_idx;                          // Next plaintext index expected
    logic        run_active;                       // Strobes are allowed
    int          cycles;
    int          mismatch_count;
    int          protocol_count;                   // Missing or extra strobes
    int unsigned seed_ret;

    rc4_decrypt_top #(
        .MSG_LEN    (MSG_LEN),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut0 (
        .clk        (clk),
        .reset_n    (reset_n),
        .start      (start),
        .secret_key (secret_key),
        .ct_load    (ct_load),
        .ct_in      (ct_in),
        .pt_valid   (pt_valid),
        .pt_out     (pt_out),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                     // Period 4
    end

    // RC4 model with identity fill, key schedule and keystream XOR
    function automatic msg_vec_t rc4_ref(input rc4_key_t key, input msg_vec_t ct);
        byte_t    s [256];
        byte_t    key_b [KEY_BYTES];
        byte_t    i;
        byte_t    j;
        byte_t    t;
        byte_t    k_addr;
        msg_vec_t pt;
        int       n;
        pt       = '0;
        key_b[0] = key[23:16];                     // Most significant byte comes first
        key_b[1] = key[15:8];
        key_b[2] = key[7:0];
        for (n = 0; n < 256; n++) begin
            s[n] = byte_t'(n);
        end
        j = 8'd0;
        for (n = 0; n < 256; n++) begin
            j    = j + s[n] + key_b[n % KEY_BYTES];
            t    = s[n];
            s[n] = s[j];
            s[j] = t;
        end
        i = 8'd0;
        j = 8'd0;
        for (n = 0; n < MSG_LEN; n++) begin
            i      = i + 8'd1;
            j      = j + s[i];
            t      = s[i];
            s[i]   = s[j];
            s[j]   = t;
            k_addr = s[i] + s[j];                  // Wraps mod 256
            pt[n]  = ct[n] ^ s[k_addr];
        end
        return pt;
    endfunction

    task automatic check_pt(input pt_beat_t actual, input pt_beat_t expected,
                            input string name);
        if (actual !== expected) begin
            $display("Mismatch %s: got index 0x%h data 0x%h, expected index 0x%h data 0x%h",
                     name, actual.index, actual.data, expected.index, expected.data);
            mismatch_count++;
        end
    endtask

    task automatic check_done(input logic actual, input logic expected, input string name);
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
            mismatch_count++;
        end
    endtask

    // Advance to 1 time unit after the next rising edge
    task automatic step_clock();
        @(posedge clk);
        #1;
    endtask

    task automatic pulse_start();
        start = 1'b1;
        step_clock();
        start = 1'b0;
    endtask

    // Fill the ciphertext store with fresh random bytes while done holds its level
    task automatic load_ciphertext(input logic done_level);
        int n;
        for (n = 0; n < MAX_MSG_LEN; n++) begin
            ct_bytes[n] = byte_t'($urandom);
            ct_load     = 1'b1;
            ct_in       = '{index: msg_idx_t'(n), data: ct_bytes[n]};
            step_clock();
            check_done(done, done_level, "done");
        end
        ct_load = 1'b0;
        ct_in   = '0;
    endtask

    // One full decrypt run with optional ignored start pulses in the middle
    task automatic run_decrypt(input rc4_key_t key, input logic mid_start,
                               input logic done_level);
        load_ciphertext(done_level);
        exp_pt     = rc4_ref(key, ct_bytes);
        exp_idx    = 0;
        run_active = 1'b1;
        secret_key = key;
        pulse_start();
        check_done(done, 1'b0, "done");            // Falls right after an accepted start
        if (mid_start) begin
            repeat (300) step_clock();             // Inside the key schedule
            pulse_start();
            while (exp_idx < MSG_LEN / 4) step_clock();
            pulse_start();                         // While plaintext is streaming
        end
        while (done !== 1'b1) step_clock();
        if (exp_idx != MSG_LEN) begin
            $display("Missing plaintext bytes: %0d of %0d strobes seen before done",
                     exp_idx, MSG_LEN);
            protocol_count++;
        end
        repeat (QUIET_CYCLES) begin
            step_clock();
            check_done(done, 1'b1, "done");        // Held until the next start
        end
        run_active = 1'b0;
    endtask

    // Compare process sampled mid-cycle where the registered outputs are stable
    always @(negedge clk) begin
        if (reset_n === 1'b1 && pt_valid === 1'b1) begin
            if (!run_active || exp_idx >= MSG_LEN) begin
                $display("Extra plaintext strobe with index 0x%h outside a run",
                         pt_out.index);
                protocol_count++;
            end else begin
                check_pt(pt_out, '{index: msg_idx_t'(exp_idx), data: exp_pt[exp_idx]},
                         "pt_out");
                exp_idx++;
            end
        end
    end

    // Cycle counter that ends a hung run
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Errors: %0d mismatches, %0d missing or extra strobes",
                 mismatch_count, protocol_count);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        reset_n        = 1'b0;
        start          = 1'b0;
        secret_key     = '0;
        ct_load        = 1'b0;
        ct_in          = '0;
        run_active     = 1'b0;
        exp_idx        = 0;
        mismatch_count = 0;
        protocol_count = 0;
        ct_bytes       = '0;
        exp_pt         = '0;
        seed_ret       = $urandom(32'h5438);       // Seed once for the whole run
        repeat (10) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // Any strobe in the quiet window after reset is flagged by the compare process
        repeat (QUIET_CYCLES) begin
            step_clock();
            check_done(done, 1'b0, "done");
        end

        run_decrypt(24'h000249, 1'b0, 1'b0);       // Fixed key
        repeat (4) begin
            run_decrypt(rc4_key_t'($urandom), 1'b0, 1'b1); // Restart from done
        end
        run_decrypt(rc4_key_t'($urandom), 1'b1, 1'b1);     // Mid-run starts ignored

        $display("Errors: %0d mismatches, %0d missing or extra strobes",
                 mismatch_count, protocol_count);
        if (mismatch_count == 0 && protocol_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rc4_props.sv */
`default_nettype none

module rc4_props (
    input logic              clk,
    input logic              reset_n,
    input logic              start,
    input logic              pt_valid,
    input rc4_pkg::pt_beat_t pt_out,
    input logic              done
);
    import rc4_pkg::*;

    logic      seen;                               // A strobe already came in this run
    msg_idx_t  prev_idx;                           // Index of the previous strobe

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            seen     <= 1'b0;
            prev_idx <= '0;
        end else if (done) begin
            seen <= 1'b0;                          // Next run starts again at index 0
        end else if (pt_valid) begin
            seen     <= 1'b1;
            prev_idx <= pt_out.index;
        end
    end

    a_valid_done_excl: assert property (@(posedge clk) disable iff (!reset_n)
        !(pt_valid && done))
        else $error("pt_valid and done high in the same cycle");

    a_start_clears_done: assert property (@(posedge clk) disable iff (!reset_n)
        (start && done) |=> !done)
        else $error("done still high after start");

    a_index_step: assert property (@(posedge clk) disable iff (!reset_n)
        (pt_valid && seen) |-> (pt_out.index == msg_idx_t'(prev_idx + 1'b1)))
        else $error("pt_out.index did not advance by one");

endmodule

bind rc4_decrypt_top rc4_props u_props (
    .clk      (clk),
    .reset_n  (reset_n),
    .start    (start),
    .pt_valid (pt_valid),
    .pt_out   (pt_out),
    .done     (done)
);

`default_nettype wire

/* rc4_decrypt_top.sv */
`default_nettype none

module rc4_decrypt_top #(
    parameter int MSG_LEN    = 32,              // Bytes decrypted per run
    parameter int FIFO_DEPTH = 4                // Keystream buffer depth
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               start,
    input  rc4_pkg::rc4_key_t  secret_key,
    input  logic               ct_load,
    input  rc4_pkg::ct_write_t ct_in,
    output logic               pt_valid,
    output rc4_pkg::pt_beat_t  pt_out,
    output logic               done
);
    import rc4_pkg::*;

    logic      ks_push;
    ks_beat_t  ks_wdata;
    logic      ks_pop;
    ks_beat_t  ks_rdata;
    logic      ks_full;
    logic      ks_empty;

    // Producer with its own S-box
    rc4_keystream #(
        .MSG_LEN (MSG_LEN)
    ) u_keystream (
        .clk        (clk),
        .reset_n    (reset_n),
        .start      (start),
        .secret_key (secret_key),
        .full       (ks_full),
        .ks_push    (ks_push),
        .ks_wdata   (ks_wdata)
    );

    keystream_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk     (clk),
        .reset_n (reset_n),
        .push    (ks_push),
        .wdata   (ks_wdata),
        .pop     (ks_pop),
        .rdata   (ks_rdata),
        .full    (ks_full),
        .empty   (ks_empty)
    );

    // Consumer with the ciphertext store
    rc4_xor_stage u_xor (
        .clk      (clk),
        .reset_n  (reset_n),
        .start    (start),
        .ct_load  (ct_load),
        .ct_in    (ct_in),
        .empty    (ks_empty),
        .ks_rdata (ks_rdata),
        .ks_pop   (ks_pop),
        .pt_valid (pt_valid),
        .pt_out   (pt_out),
        .done     (done)
    );

endmodule

`default_nettype wire

/* rc4_xor_stage.sv */
`default_nettype none

module rc4_xor_stage (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               start,           // Only taken when no run is active
    input  logic               ct_load,
    input  rc4_pkg::ct_write_t ct_in,
    input  logic               empty,           // FIFO has nothing to pop
    input  rc4_pkg::ks_beat_t  ks_rdata,        // FIFO head beat
    output logic               ks_pop,
    output logic               pt_valid,
    output rc4_pkg::pt_beat_t  pt_out,
    output logic               done
);
    import rc4_pkg::*;

    byte_t     ct_mem [MAX_MSG_LEN];            // Ciphertext store
    msg_idx_t  rd_idx;                          // Next byte to decrypt
    msg_idx_t  idx_q;
    byte_t     ct_q;                            // Registered ciphertext read
    ks_beat_t  ks_q;                            // Popped keystream beat
    logic      busy;                            // Run in progress
    logic      accept;

    assign accept = start && !busy;
    assign ks_pop = !empty;                     // Output has no back-pressure

    assign pt_out = '{index: idx_q, data: ct_q ^ ks_q.data};

    // Ciphertext memory and the pop pipeline stage
    always_ff @(posedge clk) begin
        if (ct_load) begin
            ct_mem[ct_in.index] <= ct_in.data;
        end
        if (ks_pop) begin
            ct_q  <= ct_mem[rd_idx];
            ks_q  <= ks_rdata;
            idx_q <= rd_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rd_idx   <= '0;
            pt_valid <= 1'b0;
            done     <= 1'b0;
            busy     <= 1'b0;
        end else begin
            pt_valid <= ks_pop;                 // Emit one cycle after the pop
            if (accept) begin
                rd_idx <= '0;
                done   <= 1'b0;
                busy   <= 1'b1;
            end else begin
                if (ks_pop) rd_idx <= rd_idx + 1'b1;
                if (pt_valid && ks_q.last) begin
                    done <= 1'b1;               // Rises after the final strobe
                    busy <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* keystream_fifo.sv */
`default_nettype none

module keystream_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               push,
    input  rc4_pkg::ks_beat_t  wdata,
    input  logic               pop,
    output rc4_pkg::ks_beat_t  rdata,           // Head beat, combinational
    output logic               full,
    output logic               empty
);
    import rc4_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    ks_beat_t          mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;                   // Occupancy
    logic              do_push;
    logic              do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1; // Wrap for any depth
    endfunction

    assign do_push = push && !full;             // Overflow push is dropped
    assign do_pop  = pop && !empty;
    assign full    = (count == CNT_W'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign rdata   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

/* rc4_keystream.sv */
`default_nettype none

module rc4_keystream #(
    parameter int MSG_LEN = 32                      // Keystream bytes per run
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               start,               // Accepted in IDLE or DONE only
    input  rc4_pkg::rc4_key_t  secret_key,          // Held for the whole run
    input  logic               full,                // FIFO cannot take a beat
    output logic               ks_push,
    output rc4_pkg::ks_beat_t  ks_wdata
);
    import rc4_pkg::*;

    ks_state_e   state;
    sbox_addr_t  i;                                 // RC4 index i
    sbox_addr_t  j;                                 // RC4 index j
    byte_t       si;                                // Captured S[i]
    byte_t       sj;                                // Captured S[j]
    logic [1:0]  key_sel;                           // i mod KEY_BYTES
    msg_idx_t    cnt;                               // Keystream bytes pushed so far
    logic        last_byte;
    byte_t       key_byte;
    byte_t       j_next;

    sbox_addr_t  sb_addr;
    byte_t       sb_wdata;
    logic        sb_wren;
    byte_t       sb_rdata;

    s_box_ram u_s_box (
        .clk   (clk),
        .addr  (sb_addr),
        .wdata (sb_wdata),
        .wren  (sb_wren),
        .rdata (sb_rdata)
    );

    assign key_byte  = secret_key[8 * (KEY_BYTES - 1 - key_sel) +: 8]; // Byte 0 is bits 23:16
    assign last_byte = (cnt == msg_idx_t'(MSG_LEN - 1));

    // j update, key byte only added in the key schedule
    assign j_next = j + sb_rdata + ((state == KSA_RD_J) ? key_byte : 8'd0);

    assign ks_push  = (state == PRGA_PUSH) && !full;
    assign ks_wdata = '{last: last_byte, data: sb_rdata}; // S[S[i]+S[j]] sits on rdata

    // S-box port control
    always_comb begin
        sb_addr  = i;
        sb_wdata = sb_rdata;
        sb_wren  = 1'b0;
        case (state)
            FILL: begin
                sb_wdata = i;                       // Identity permutation
                sb_wren  = 1'b1;
            end
            KSA_RD_J, PRGA_RD_J: begin
                sb_addr = j_next;                   // Fetch S[j] with the new j
            end
            KSA_WR_I, PRGA_WR_I: begin
                sb_wren = 1'b1;                     // S[i] gets S[j] straight off rdata
            end
            KSA_WR_J, PRGA_WR_J: begin
                sb_addr  = j;
                sb_wdata = si;
                sb_wren  = 1'b1;
            end
            PRGA_RD_K, PRGA_PUSH: begin
                sb_addr = si + sj;                  // Address held so rdata stays put in a stall
            end
            default: begin
                sb_addr = i;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state   <= IDLE;
            i       <= '0;
            j       <= '0;
            key_sel <= '0;
            cnt     <= '0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (start) begin
                        state <= FILL;
                        i     <= '0;
                    end
                end
                FILL: begin
                    i <= i + 8'd1;
                    if (i == 8'hFF) begin
                        state   <= KSA_RD_I;        // i wraps back to 0
                        j       <= '0;
                        key_sel <= '0;
                    end
                end
                KSA_RD_I: state <= KSA_RD_J;
                KSA_RD_J: begin
                    si    <= sb_rdata;
                    j     <= j_next;
                    state <= KSA_WR_I;
                end
                KSA_WR_I: begin
                    sj    <= sb_rdata;
                    state <= KSA_WR_J;
                end
                KSA_WR_J: begin
                    key_sel <= (key_sel == 2'(KEY_BYTES - 1)) ? 2'd0 : key_sel + 2'd1;
                    if (i == 8'hFF) begin
                        state <= PRGA_RD_I;
                        i     <= 8'd1;              // First generator step uses i = 1
                        j     <= '0;
                        cnt   <= '0;
                    end else begin
                        i     <= i + 8'd1;
                        state <= KSA_RD_I;
                    end
                end
                PRGA_RD_I: state <= PRGA_RD_J;
                PRGA_RD_J: begin
                    si    <= sb_rdata;
                    j     <= j_next;
                    state <= PRGA_WR_I;
                end
                PRGA_WR_I: begin
                    sj    <= sb_rdata;
                    state <= PRGA_WR_J;
                end
                PRGA_WR_J: state <= PRGA_RD_K;
                PRGA_RD_K: state <= PRGA_PUSH;
                PRGA_PUSH: begin
                    if (!full) begin                // Stall here while the FIFO is full
                        cnt <= cnt + 1'b1;
                        i   <= i + 8'd1;
                        state <= last_byte ? DONE : PRGA_RD_I;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* s_box_ram.sv */
`default_nettype none

module s_box_ram (
    input  logic                 clk,
    input  rc4_pkg::sbox_addr_t  addr,      // Shared read and write address
    input  rc4_pkg::byte_t       wdata,
    input  logic                 wren,
    output rc4_pkg::byte_t       rdata      // Registered read data
);
    import rc4_pkg::*;

    localparam int DEPTH = 2 ** $bits(sbox_addr_t); // 256 state bytes

    byte_t mem [DEPTH];                             // RC4 state array

    // Single port with read-before-write, like the FPGA block RAM
    always_ff @(posedge clk) begin
        if (wren) begin
            mem[addr] <= wdata;                     // Write takes the port
        end
        rdata <= mem[addr];                         // Old contents on a write cycle
    end

endmodule

`default_nettype wire

/* rc4_pkg.sv */
`default_nettype none

package rc4_pkg;

    localparam int MAX_MSG_LEN = 32;                   // Size of the ciphertext store
    localparam int KEY_BYTES   = 3;                    // Secret key length in bytes

    typedef logic [7:0]  byte_t;                       // Data or keystream byte
    typedef logic [7:0]  sbox_addr_t;                  // S-box index
    typedef logic [23:0] rc4_key_t;                    // Secret key, MSB byte is key byte 0
    typedef logic [$clog2(MAX_MSG_LEN)-1:0] msg_idx_t; // Message byte index

    // One keystream byte on its way from the generator to the XOR stage
    typedef struct packed {
        logic  last;                                   // Final byte of the message
        byte_t data;                                   // Keystream byte
    } ks_beat_t;

    typedef struct packed {
        msg_idx_t index;                               // Target ciphertext slot
        byte_t    data;                                // Ciphertext byte
    } ct_write_t;

    typedef struct packed {
        msg_idx_t index;                               // Plaintext position
        byte_t    data;                                // Plaintext byte
    } pt_beat_t;

    // Keystream producer FSM
    typedef enum logic [3:0] {
        IDLE,                                          // Waiting for start after reset
        FILL,                                          // S[i] = i
        KSA_RD_I,                                      // Issue read of S[i]
        KSA_RD_J,                                      // New j, issue read of S[j]
        KSA_WR_I,                                      // S[i] <= old S[j]
        KSA_WR_J,                                      // S[j] <= old S[i]
        PRGA_RD_I,
        PRGA_RD_J,
        PRGA_WR_I,
        PRGA_WR_J,
        PRGA_RD_K,                                     // Read S[S[i]+S[j]]
        PRGA_PUSH,                                     // Hand keystream byte to the FIFO
        DONE                                           // Run finished, restartable
    } ks_state_e;

endpackage

`default_nettype wire
